// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // datapath and address width
    localparam int xlen = 32;
    // register index width for 32 registers
    localparam int reg_addr_w = 5;

    // operation class codes
    typedef enum logic [2:0] {
        cls_r = 3'b000,
        cls_i = 3'b001,
        cls_s = 3'b010,
        cls_b = 3'b011,
        cls_u = 3'b100,
        cls_j = 3'b101
    } op_class_e;

    // alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // major opcodes in instr[6:0]
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    // stores decode but are not executed here
    localparam logic [6:0] opc_store  = 7'b0100011;

    // branch conditions in the funct3 field
    localparam logic [2:0] br_beq  = 3'b000;
    localparam logic [2:0] br_bne  = 3'b001;
    localparam logic [2:0] br_blt  = 3'b100;
    localparam logic [2:0] br_bge  = 3'b101;
    localparam logic [2:0] br_bltu = 3'b110;
    localparam logic [2:0] br_bgeu = 3'b111;

endpackage

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_e         alu_op,
    input  wire logic [rv_pkg::xlen-1:0] a,
    input  wire logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0]      alu_result
);

    import rv_pkg::*;

    // shift amount is the low five bits of b
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb
    begin
        case (alu_op)
            alu_add:
                alu_result = a + b;
            alu_sub:
                alu_result = a - b;
            alu_sll:
                alu_result = a << shamt;
            // compares give 0 or 1
            alu_slt:
                alu_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:
                alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:
                alu_result = a ^ b;
            alu_srl:
                alu_result = a >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:
                alu_result = $unsigned($signed(a) >>> shamt);
            alu_or:
                alu_result = a | b;
            alu_and:
                alu_result = a & b;
            default:
                alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: instr_decode.sv
`default_nettype none

module instr_decode (
    input  wire logic [rv_pkg::xlen-1:0]       instr,
    output rv_pkg::op_class_e                  op_class,
    output rv_pkg::alu_op_e                    alu_op,
    output logic [rv_pkg::xlen-1:0]            imm,
    output logic [rv_pkg::reg_addr_w-1:0]      rs1,
    output logic [rv_pkg::reg_addr_w-1:0]      rs2,
    output logic [rv_pkg::reg_addr_w-1:0]      rd,
    output logic [2:0]                         funct3,
    output logic                               use_pc,
    output logic                               is_jalr,
    output logic                               dec_illegal
);

    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;
    // alu op from funct3, sub allowed or not
    alu_op_e         reg_op;
    alu_op_e         imm_op;
    logic            f7_zero;
    logic            f7_alt;

    // fixed field positions
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // immediates, all sign extended from instr[31]
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // lui and auipc share a class
    assign use_pc  = (opcode == opc_auipc);
    assign is_jalr = (opcode == opc_jalr);

    // funct3 to alu op, instr[30] picks sub and sra
    always_comb
    begin
        case (funct3)
            3'b000:  imm_op = alu_add;
            3'b001:  imm_op = alu_sll;
            3'b010:  imm_op = alu_slt;
            3'b011:  imm_op = alu_sltu;
            3'b100:  imm_op = alu_xor;
            3'b101:  imm_op = instr[30] ? alu_sra : alu_srl;
            3'b110:  imm_op = alu_or;
            default: imm_op = alu_and;
        endcase
        // only register form has sub
        reg_op = (funct3 == 3'b000 && instr[30]) ? alu_sub : imm_op;
    end

    always_comb
    begin
        op_class    = cls_i;
        alu_op      = alu_add;
        imm         = i_imm;
        dec_illegal = 1'b0;
        case (opcode)
            opc_op:
            begin
                op_class = cls_r;
                alu_op   = reg_op;
                // funct7 alt form only for sub and sra
                if (!f7_zero && !(f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))
                    dec_illegal = 1'b1;
            end
            opc_op_imm:
            begin
                alu_op = imm_op;
                // shift immediates carry funct7 in the upper bits
                if (funct3 == 3'b001 && !f7_zero)
                    dec_illegal = 1'b1;
                if (funct3 == 3'b101 && !f7_zero && !f7_alt)
                    dec_illegal = 1'b1;
            end
            opc_jalr:
                op_class = cls_i;
            opc_lui, opc_auipc:
            begin
                op_class = cls_u;
                imm      = u_imm;
            end
            opc_branch:
            begin
                op_class = cls_b;
                imm      = b_imm;
                // funct3 2 and 3 are not branches
                case (funct3)
                    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu: dec_illegal = 1'b0;
                    default: dec_illegal = 1'b1;
                endcase
            end
            opc_jal:
            begin
                op_class = cls_j;
                imm      = j_imm;
            end
            opc_store:
            begin
                // no memory in this path
                op_class    = cls_s;
                imm         = s_imm;
                dec_illegal = 1'b1;
            end
            default:
                dec_illegal = 1'b1;
        endcase
    end

    // a legal decode never lands in the store class
    store_never_legal: assert final (dec_illegal || op_class != cls_s);

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  wire logic                          we,
    input  wire logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  wire logic [rv_pkg::xlen-1:0]       wdata,
    output logic [rv_pkg::xlen-1:0]            rs1_value,
    output logic [rv_pkg::xlen-1:0]            rs2_value
);

    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 reads as zero
    always_comb
    begin
        rs1_value = (rs1 == '0) ? '0 : regs[rs1];
        rs2_value = (rs2 == '0) ? '0 : regs[rs2];
    end

    // execute filters rd == 0 before raising we
    no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> (waddr != '0));

endmodule

`default_nettype wire

// File: execute.sv
`default_nettype none

module execute (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          instr_valid,
    input  wire rv_pkg::op_class_e             op_class,
    input  wire rv_pkg::alu_op_e               alu_op,
    input  wire logic [rv_pkg::xlen-1:0]       imm,
    input  wire logic [rv_pkg::xlen-1:0]       rs1_value,
    input  wire logic [rv_pkg::xlen-1:0]       rs2_value,
    input  wire logic [rv_pkg::reg_addr_w-1:0] rd,
    input  wire logic [2:0]                    funct3,
    input  wire logic                          use_pc,
    input  wire logic                          is_jalr,
    input  wire logic                          dec_illegal,
    input  wire logic [rv_pkg::xlen-1:0]       pc,
    output logic                               we,
    output logic [rv_pkg::reg_addr_w-1:0]      waddr,
    output logic [rv_pkg::xlen-1:0]            wdata,
    output logic                               wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0]      wb_rd,
    output logic [rv_pkg::xlen-1:0]            wb_data,
    output logic                               branch_taken,
    output logic [rv_pkg::xlen-1:0]            branch_target,
    output logic                               illegal
);

    import rv_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    alu_op_e         sel_op;
    logic [xlen-1:0] alu_result;
    logic            cond;
    logic            is_jump;
    logic            writes_rd;
    logic            take;
    logic [xlen-1:0] target;
    logic [xlen-1:0] jalr_sum;

    alu u_alu (
        .alu_op     (sel_op),
        .a          (a),
        .b          (b),
        .alu_result (alu_result)
    );

    // alu input select by class
    always_comb
    begin
        a      = rs1_value;
        b      = rs2_value;
        sel_op = alu_add;
        case (op_class)
            cls_r:
                sel_op = alu_op;
            cls_i:
            begin
                if (is_jalr)
                begin
                    // link value pc + 4
                    a = pc;
                    b = xlen'(4);
                end
                else
                begin
                    b      = imm;
                    sel_op = alu_op;
                end
            end
            cls_u:
            begin
                // auipc adds pc, lui adds zero
                a = use_pc ? pc : '0;
                b = imm;
            end
            cls_j:
            begin
                a = pc;
                b = xlen'(4);
            end
            default:
            begin
                a = rs1_value;
                b = rs2_value;
            end
        endcase
    end

    // branch condition on the raw register values
    always_comb
    begin
        case (funct3)
            br_beq:  cond = (rs1_value == rs2_value);
            br_bne:  cond = (rs1_value != rs2_value);
            br_blt:  cond = ($signed(rs1_value) < $signed(rs2_value));
            br_bge:  cond = ($signed(rs1_value) >= $signed(rs2_value));
            br_bltu: cond = (rs1_value < rs2_value);
            br_bgeu: cond = (rs1_value >= rs2_value);
            default: cond = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign jalr_sum = rs1_value + imm;
    assign target   = is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

    assign is_jump   = (op_class == cls_j) || (op_class == cls_i && is_jalr);
    assign writes_rd = (op_class == cls_r) || (op_class == cls_i) ||
                       (op_class == cls_u) || (op_class == cls_j);
    assign take      = instr_valid && !dec_illegal &&
                       (is_jump || (op_class == cls_b && cond));

    // write port, lands on the same edge as the outputs
    assign we    = instr_valid && !dec_illegal && writes_rd && (rd != '0);
    assign waddr = rd;
    assign wdata = alu_result;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid      <= 1'b0;
            wb_rd         <= '0;
            wb_data       <= '0;
            branch_taken  <= 1'b0;
            branch_target <= '0;
            illegal       <= 1'b0;
        end
        else
        begin
            wb_valid     <= we;
            branch_taken <= take;
            illegal      <= instr_valid && dec_illegal;
            // payload held until the next write or redirect
            if (we)
            begin
                wb_rd   <= rd;
                wb_data <= alu_result;
            end
            if (take)
                branch_target <= target;
        end
    end

    // a flagged instruction never redirects
    no_taken_illegal: assert property (@(posedge clk) disable iff (rst)
        !(branch_taken && illegal));

    // every output pulse traces back to a strobe one cycle earlier
    pulse_needs_valid: assert property (@(posedge clk) disable iff (rst)
        (wb_valid || branch_taken || illegal) |-> $past(instr_valid));

endmodule

`default_nettype wire

// File: exec_core.sv
`default_nettype none

module exec_core (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     instr_valid,
    input  wire logic [rv_pkg::xlen-1:0]  instr,
    input  wire logic [rv_pkg::xlen-1:0]  pc,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          branch_taken,
    output logic [rv_pkg::xlen-1:0]       branch_target,
    output logic                          illegal
);

    import rv_pkg::*;

    // decoded fields
    op_class_e             op_class;
    alu_op_e               alu_op;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [2:0]            funct3;
    logic                  use_pc;
    logic                  is_jalr;
    logic                  dec_illegal;
    // register file ports
    logic [xlen-1:0]       rs1_value;
    logic [xlen-1:0]       rs2_value;
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;

    instr_decode u_decode (
        .instr       (instr),
        .op_class    (op_class),
        .alu_op      (alu_op),
        .imm         (imm),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .funct3      (funct3),
        .use_pc      (use_pc),
        .is_jalr     (is_jalr),
        .dec_illegal (dec_illegal)
    );

    reg_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    // write port driven back from execute
    execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .op_class      (op_class),
        .alu_op        (alu_op),
        .imm           (imm),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .rd            (rd),
        .funct3        (funct3),
        .use_pc        (use_pc),
        .is_jalr       (is_jalr),
        .dec_illegal   (dec_illegal),
        .pc            (pc),
        .we            (we),
        .waddr         (waddr),
        .wdata         (wdata),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal       (illegal)
    );

endmodule

`default_nettype wire

// File: tb_exec_core.sv
`default_nettype none

module tb_exec_core;

    import rv_pkg::*;

    // 36 r, 22 i, 8 upper, 24 branch, 6 jump and 10 x0 or illegal cycles
    localparam int issue_count = 106;
    localparam int cycle_limit = 2 * issue_count + 50;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  branch_taken;
    logic [xlen-1:0]       branch_target;
    logic                  illegal;

    // reference copy of the register file
    logic [xlen-1:0]       model [0:31];
    int unsigned           seed;
    int                    cycles;

    exec_core uut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal       (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit counted in rising edges
    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the cycle limit");
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // one instruction builder per format
    function automatic logic [31:0] r_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] j_word(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // isa semantics of the alu group with alt as instr bit 30
    function automatic logic [31:0] ref_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one instruction checked at the falling edge after its rising edge
    task automatic issue(input string name, input logic [31:0] word, input logic [31:0] pc_in,
                         input logic exp_wb, input logic [4:0] exp_rd, input logic [31:0] exp_data,
                         input logic exp_taken, input logic [31:0] exp_target, input logic exp_ill);
        instr       = word;
        pc          = pc_in;
        instr_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        instr_valid = 1'b0;
        check({name, " wb_valid"}, 32'(exp_wb), 32'(wb_valid));
        if (exp_wb)
        begin
            check({name, " wb_rd"}, 32'(exp_rd), 32'(wb_rd));
            check({name, " wb_data"}, exp_data, wb_data);
            model[exp_rd] = exp_data;
        end
        check({name, " branch_taken"}, 32'(exp_taken), 32'(branch_taken));
        // target only holds meaning on a redirect
        if (exp_taken)
            check({name, " branch_target"}, exp_target, branch_target);
        check({name, " illegal"}, 32'(exp_ill), 32'(illegal));
    endtask

    // word on the bus with the strobe low, nothing may retire
    task automatic idle_cycle(input string name, input logic [31:0] word);
        instr       = word;
        pc          = 32'h420;
        instr_valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check({name, " wb_valid"}, 32'd0, 32'(wb_valid));
        check({name, " branch_taken"}, 32'd0, 32'(branch_taken));
        check({name, " illegal"}, 32'd0, 32'(illegal));
    endtask

    task automatic write_issue(input string name, input logic [31:0] word,
                               input logic [31:0] pc_in, input logic [4:0] rd,
                               input logic [31:0] data);
        issue(name, word, pc_in, rd != 5'd0, rd, data, 1'b0, 32'd0, 1'b0);
    endtask

    // lui then addi with the upper part rounded for the signed low half
    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        write_issue("load lui", u_word(hi[31:12], r, opc_lui), 32'h100, r, {hi[31:12], 12'b0});
        write_issue("load addi", i_word(v[11:0], r, 3'b000, r, opc_op_imm), 32'h104, r, v);
    endtask

    task automatic test_r_type();
        logic [31:0] v;
        logic [4:0]  s1;
        logic [4:0]  s2;
        string       name;
        for (int r = 1; r <= 8; r++)
        begin
            v = $urandom;
            // x7 negative and x3 positive
            if (r == 7)
                v[31] = 1'b1;
            if (r == 3)
                v[31] = 1'b0;
            load_reg(r[4:0], v);
        end
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int alt = 0; alt < 2; alt++)
            begin
                if (alt == 0 || f3 == 0 || f3 == 5)
                begin
                    for (int p = 0; p < 2; p++)
                    begin
                        s1   = (p != 0) ? 5'd7 : 5'd1;
                        s2   = (p != 0) ? 5'd3 : 5'd2;
                        name = $sformatf("test_r_type f3=%0d alt=%0d", f3, alt);
                        write_issue(name, r_word((alt != 0) ? 7'b0100000 : 7'b0, f3[2:0], 5'd10,
                                    s1, s2), 32'h200, 5'd10,
                                    ref_op(f3[2:0], alt[0], model[s1], model[s2]));
                    end
                end
            end
        end
    endtask

    task automatic test_i_type();
        logic [11:0] imm;
        logic [4:0]  s1;
        logic        alt;
        string       name;
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int a = 0; a < 2; a++)
            begin
                if (a == 0 || f3 == 5)
                begin
                    for (int p = 0; p < 2; p++)
                    begin
                        s1  = (p != 0) ? 5'd7 : 5'd1;
                        alt = a[0];
                        imm = $urandom;
                        if (f3 == 1 || f3 == 5)
                            imm[11:5] = alt ? 7'b0100000 : 7'b0;
                        else
                            imm[11] = p[0];
                        name = $sformatf("test_i_type f3=%0d alt=%0d", f3, a);
                        write_issue(name, i_word(imm, s1, f3[2:0], 5'd20, opc_op_imm), 32'h300,
                                    5'd20, ref_op(f3[2:0], alt, model[s1],
                                    {{20{imm[11]}}, imm}));
                    end
                end
            end
        end
        // back to back chain where each step reads the previous result
        write_issue("test_i_type chain 0", i_word(12'h7f1, 5'd1, 3'b000, 5'd21, opc_op_imm),
                    32'h310, 5'd21, model[1] + 32'h7f1);
        write_issue("test_i_type chain 1", i_word(12'h805, 5'd21, 3'b000, 5'd22, opc_op_imm),
                    32'h314, 5'd22, model[21] + 32'hffff_f805);
        write_issue("test_i_type chain 2", i_word(12'h0f0, 5'd22, 3'b100, 5'd23, opc_op_imm),
                    32'h318, 5'd23, model[22] ^ 32'h0f0);
        write_issue("test_i_type chain 3", r_word(7'b0, 3'b000, 5'd24, 5'd23, 5'd21),
                    32'h31c, 5'd24, model[23] + model[21]);
    endtask

    task automatic test_upper();
        logic [19:0] imm;
        logic [31:0] pcv;
        for (int k = 0; k < 4; k++)
        begin
            imm = $urandom;
            pcv = $urandom & 32'hffff_fffc;
            write_issue("test_upper lui", u_word(imm, 5'd25, opc_lui), pcv, 5'd25, {imm, 12'b0});
            write_issue("test_upper auipc", u_word(imm, 5'd26, opc_auipc), pcv, 5'd26,
                        pcv + {imm, 12'b0});
        end
    endtask

    task automatic test_branch();
        logic [2:0]  conds [0:5];
        logic [4:0]  lhs [0:2];
        logic [4:0]  rhs [0:2];
        logic [31:0] rnd;
        logic [12:0] imm;
        logic [31:0] pcv;
        logic        taken;
        conds = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
        // equal pair then negative against small positive both ways
        lhs   = '{5'd28, 5'd27, 5'd28};
        rhs   = '{5'd29, 5'd28, 5'd27};
        load_reg(5'd27, 32'hffff_fff0);
        load_reg(5'd28, 32'h0000_0010);
        load_reg(5'd29, 32'h0000_0010);
        for (int c = 0; c < 6; c++)
        begin
            for (int p = 0; p < 3; p++)
            begin
                rnd   = $urandom;
                imm   = {rnd[11:0], 1'b0};
                pcv   = $urandom & 32'hffff_fffc;
                taken = ref_branch(conds[c], model[lhs[p]], model[rhs[p]]);
                issue($sformatf("test_branch f3=%0d pair=%0d", conds[c], p),
                      b_word(imm, lhs[p], rhs[p], conds[c]), pcv, 1'b0, 5'd0, 32'd0,
                      taken, pcv + {{19{imm[12]}}, imm}, 1'b0);
            end
        end
    endtask

    task automatic test_jump();
        logic [31:0] rnd;
        logic [31:0] pcv;
        logic [20:0] jimm;
        logic [11:0] iimm;
        logic [31:0] sum;
        for (int k = 0; k < 3; k++)
        begin
            rnd  = $urandom;
            pcv  = $urandom & 32'hffff_fffc;
            jimm = {rnd[19:0], 1'b0};
            issue("test_jump jal", j_word(jimm, 5'd30), pcv, 1'b1, 5'd30, pcv + 32'd4,
                  1'b1, pcv + {{11{jimm[20]}}, jimm}, 1'b0);
            iimm = rnd[31:20];
            sum  = model[1] + {{20{iimm[11]}}, iimm};
            issue("test_jump jalr", i_word(iimm, 5'd1, 3'b000, 5'd31, opc_jalr), pcv, 1'b1,
                  5'd31, pcv + 32'd4, 1'b1, {sum[31:1], 1'b0}, 1'b0);
        end
    endtask

    task automatic test_x0_illegal();
        // x0 target gives no write-back
        issue("test_x0 addi", i_word(12'h123, 5'd1, 3'b000, 5'd0, opc_op_imm), 32'h400,
              1'b0, 5'd0, 32'd0, 1'b0, 32'd0, 1'b0);
        write_issue("test_x0 readback", i_word(12'h123, 5'd0, 3'b000, 5'd9, opc_op_imm),
                    32'h404, 5'd9, 32'h123);
        issue("test_x0 jal", j_word(21'h40, 5'd0), 32'h408, 1'b0, 5'd0, 32'd0,
              1'b1, 32'h448, 1'b0);
        // every illegal form names x10 as its rd
        issue("test_illegal store", {7'h0, 5'd2, 5'd1, 3'b010, 5'd10, opc_store}, 32'h40c,
              1'b0, 5'd0, 32'd0, 1'b0, 32'd0, 1'b1);
        issue("test_illegal opcode", 32'h0000_050b, 32'h410, 1'b0, 5'd0, 32'd0,
              1'b0, 32'd0, 1'b1);
        issue("test_illegal funct7", r_word(7'b0000001, 3'b000, 5'd10, 5'd1, 5'd2), 32'h414,
              1'b0, 5'd0, 32'd0, 1'b0, 32'd0, 1'b1);
        issue("test_illegal branch f3", b_word(13'h0a, 5'd1, 5'd2, 3'b010), 32'h418,
              1'b0, 5'd0, 32'd0, 1'b0, 32'd0, 1'b1);
        // without the strobe a jal to x10 and a store do nothing
        idle_cycle("test_idle jal", j_word(21'h40, 5'd10));
        idle_cycle("test_idle store", {7'h0, 5'd2, 5'd1, 3'b010, 5'd10, opc_store});
        write_issue("test_illegal x10 kept", i_word(12'h0, 5'd10, 3'b000, 5'd11, opc_op_imm),
                    32'h41c, 5'd11, model[10]);
    endtask

    initial
    begin
        seed = 32'h6cc3e1a6;
        void'($urandom(seed));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        for (int r = 0; r < 32; r++)
        begin
            model[r] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("reset wb_valid", 32'd0, 32'(wb_valid));
        check("reset branch_taken", 32'd0, 32'(branch_taken));
        check("reset illegal", 32'd0, 32'(illegal));
        check("reset wb_rd", 32'd0, 32'(wb_rd));
        check("reset wb_data", 32'd0, wb_data);
        check("reset branch_target", 32'd0, branch_target);
        test_r_type();
        test_i_type();
        test_upper();
        test_branch();
        test_jump();
        test_x0_illegal();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rv_pkg.sv
alu.sv
instr_decode.sv
reg_file.sv
execute.sv
exec_core.sv
tb_exec_core.sv
